/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////

    localparam int tag_w          = 20;
    localparam int index_w        = 7;
    localparam int word_sel_w     = 3;
    localparam int words_per_line = 8;
    localparam int line_w         = 256;
    localparam int num_sets       = 1 << index_w;

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // 20 + 7 + 3 + 2 = 32 bits
    typedef struct packed {
        logic [tag_w-1:0]      tag;
        logic [index_w-1:0]    index;
        logic [word_sel_w-1:0] word_sel;
        logic [1:0]            byte_off;
    } cache_addr_t;

    // one processor request, 70 bits
    typedef struct packed {
        logic        rd;
        logic        wr;
        cache_addr_t addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } cache_req_t;

    // word 0 sits in the low 32 bits
    typedef logic [words_per_line-1:0][line_w/words_per_line-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        miss_idle   = 2'd0,
        miss_wb     = 2'd1,
        miss_refill = 2'd2
    } miss_state_t;

endpackage

`default_nettype wire

/* dcache_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              rvalid_i,
    input  wire logic              wvalid_i,
    input  wire logic [31:0]       paddr_i,
    input  wire logic [3:0]        wsel_i,
    input  wire logic [31:0]       wdata_i,
    input  wire logic              stall_i,
    output dcache_pkg::cache_req_t req_o
);

    dcache_pkg::cache_req_t req_q;

    // request flags
    always_ff @(posedge clk) begin
        if (!rst) begin
            req_q.rd <= 1'b0;
            req_q.wr <= 1'b0;
        end else if (!stall_i) begin
            req_q.rd <= rvalid_i;
            req_q.wr <= wvalid_i;
        end
    end

    // address and write payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            req_q.addr  <= dcache_pkg::cache_addr_t'(paddr_i);
            req_q.strb  <= wsel_i;
            req_q.wdata <= wdata_i;
        end
    end

    assign req_o = req_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // processor must not present a read and a write at once
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(req_q.rd && req_q.wr)
    );

endmodule

`default_nettype wire

/* dcache_tag_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire dcache_pkg::cache_req_t req_i,
    input  wire logic                   ret_valid_i,
    input  wire logic                   wr_valid_i,
    output logic                        stall_o,
    output logic                        data_ok_o,
    output logic                        rd_req_o,
    output logic [31:0]                 rd_addr_o,
    output logic                        wr_req_o,
    output logic [31:0]                 wr_addr_o,
    output logic [1:0]                  hit_way_o,
    output logic                        fill_way_o,
    output logic                        fill_en_o,
    output logic                        hit_wr_en_o
);

    localparam int sets = dcache_pkg::num_sets;

    dcache_pkg::tag_entry_t  tag_way [2][sets];
    logic [sets-1:0]         dirty_q [2];
    logic [sets-1:0]         lru_q;
    dcache_pkg::miss_state_t state_q;

    logic [dcache_pkg::index_w-1:0] idx;
    logic                           req_v;
    logic                           hit;
    logic                           miss;
    logic                           victim;
    logic                           victim_dirty;
    dcache_pkg::tag_entry_t         victim_entry;

    assign idx   = req_i.addr.index;
    assign req_v = req_i.rd | req_i.wr;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way_o[w] = req_v && tag_way[w][idx].valid &&
                           (tag_way[w][idx].tag == req_i.addr.tag);
        end
    end

    assign hit  = |hit_way_o;
    assign miss = req_v & ~hit;

    // lru bit names the way to replace
    assign victim       = lru_q[idx];
    assign victim_dirty = dirty_q[victim][idx];
    assign victim_entry = tag_way[victim][idx];

    assign fill_way_o  = victim;
    assign fill_en_o   = (state_q == dcache_pkg::miss_refill) & ret_valid_i;
    assign hit_wr_en_o = hit & req_i.wr;

    assign stall_o   = miss & ~fill_en_o;
    assign data_ok_o = req_i.rd & (hit | fill_en_o);

    assign rd_req_o  = (state_q == dcache_pkg::miss_refill);
    assign wr_req_o  = (state_q == dcache_pkg::miss_wb);
    assign rd_addr_o = {req_i.addr.tag, idx, {(dcache_pkg::word_sel_w + 2){1'b0}}};
    assign wr_addr_o = {victim_entry.tag, idx, {(dcache_pkg::word_sel_w + 2){1'b0}}};

    ////////////////////////////////////////
    // miss sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= dcache_pkg::miss_idle;
        end else begin
            case (state_q)
                dcache_pkg::miss_idle: begin
                    if (miss) begin
                        state_q <= victim_dirty ? dcache_pkg::miss_wb
                                                : dcache_pkg::miss_refill;
                    end
                end
                dcache_pkg::miss_wb: begin
                    if (wr_valid_i) begin
                        state_q <= dcache_pkg::miss_refill;
                    end
                end
                dcache_pkg::miss_refill: begin
                    if (ret_valid_i) begin
                        state_q <= dcache_pkg::miss_idle;
                    end
                end
                default: state_q <= dcache_pkg::miss_idle;
            endcase
        end
    end

    // tag and valid arrays
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < sets; s++) begin
                tag_way[0][s].valid <= 1'b0;
                tag_way[1][s].valid <= 1'b0;
            end
        end else if (fill_en_o) begin
            tag_way[victim][idx] <= {1'b1, req_i.addr.tag};
        end
    end

    // lru and dirty
    always_ff @(posedge clk) begin
        if (!rst) begin
            lru_q      <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
        end else if (fill_en_o) begin
            lru_q[idx]           <= ~victim;
            dirty_q[victim][idx] <= req_i.wr;
        end else if (hit) begin
            // point at the way that was not used
            lru_q[idx] <= hit_way_o[0];
            if (req_i.wr) begin
                dirty_q[hit_way_o[1]][idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_hit_one_way: assert property (
        @(posedge clk) disable iff (!rst)
        !(hit_way_o[0] && hit_way_o[1])
    );

    a_mem_req_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(rd_req_o && wr_req_o)
    );

    a_fill_on_return: assert property (
        @(posedge clk) disable iff (!rst)
        fill_en_o |-> ret_valid_i && rd_req_o
    );

endmodule

`default_nettype wire

/* dcache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire dcache_pkg::cache_req_t req_i,
    input  wire dcache_pkg::line_t      ret_data_i,
    input  wire logic [1:0]             hit_way_i,
    input  wire logic                   fill_way_i,
    input  wire logic                   fill_en_i,
    input  wire logic                   hit_wr_en_i,
    output logic [31:0]                 rdata_o,
    output dcache_pkg::line_t           victim_o
);

    dcache_pkg::line_t data_way [2][dcache_pkg::num_sets];

    logic [dcache_pkg::index_w-1:0]    idx;
    logic [dcache_pkg::word_sel_w-1:0] word;
    dcache_pkg::line_t                 hit_line;
    dcache_pkg::line_t                 fill_line;
    logic [31:0]                       hit_word;

    assign idx  = req_i.addr.index;
    assign word = req_i.addr.word_sel;

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    assign hit_line = hit_way_i[1] ? data_way[1][idx] : data_way[0][idx];
    assign hit_word = hit_line[word];
    assign victim_o = data_way[fill_way_i][idx];

    // refill word goes straight through
    assign rdata_o = fill_en_i ? ret_data_i[word] : hit_word;

    // write miss merges into the returned line
    always_comb begin
        fill_line = ret_data_i;
        if (req_i.wr) begin
            fill_line[word] = merge_bytes(ret_data_i[word], req_i.wdata, req_i.strb);
        end
    end

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    // no array writes while in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            if (fill_en_i) begin
                data_way[fill_way_i][idx] <= fill_line;
            end else if (hit_wr_en_i) begin
                data_way[hit_way_i[1]][idx][word] <=
                    merge_bytes(hit_word, req_i.wdata, req_i.strb);
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_one_write_source: assert property (
        @(posedge clk) disable iff (!rst)
        !(fill_en_i && hit_wr_en_i)
    );

    a_hit_write_way: assert property (
        @(posedge clk) disable iff (!rst)
        hit_wr_en_i |-> $onehot(hit_way_i)
    );

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic         clk,
    input  wire logic         rst,
    // processor side
    input  wire logic         rvalid_i,
    input  wire logic         wvalid_i,
    input  wire logic [31:0]  paddr_i,
    input  wire logic [3:0]   wsel_i,
    input  wire logic [31:0]  wdata_i,
    output logic              stall_o,
    output logic              data_ok_o,
    output logic [31:0]       rdata_o,
    // memory side
    output logic              rd_req_o,
    output logic [31:0]       rd_addr_o,
    input  wire logic         ret_valid_i,
    input  wire logic [255:0] ret_data_i,
    output logic              wr_req_o,
    output logic [31:0]       wr_addr_o,
    output logic [255:0]      wr_data_o,
    input  wire logic         wr_valid_i
);

    dcache_pkg::cache_req_t req_q;
    logic [1:0]             hit_way;
    logic                   fill_way;
    logic                   fill_en;
    logic                   hit_wr_en;

    dcache_req_stage u_req_stage (
        .clk      (clk),
        .rst      (rst),
        .rvalid_i (rvalid_i),
        .wvalid_i (wvalid_i),
        .paddr_i  (paddr_i),
        .wsel_i   (wsel_i),
        .wdata_i  (wdata_i),
        .stall_i  (stall_o),
        .req_o    (req_q)
    );

    dcache_tag_ctrl u_tag_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_q),
        .ret_valid_i (ret_valid_i),
        .wr_valid_i  (wr_valid_i),
        .stall_o     (stall_o),
        .data_ok_o   (data_ok_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .wr_req_o    (wr_req_o),
        .wr_addr_o   (wr_addr_o),
        .hit_way_o   (hit_way),
        .fill_way_o  (fill_way),
        .fill_en_o   (fill_en),
        .hit_wr_en_o (hit_wr_en)
    );

    dcache_data_store u_data_store (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_q),
        .ret_data_i  (ret_data_i),
        .hit_way_i   (hit_way),
        .fill_way_i  (fill_way),
        .fill_en_i   (fill_en),
        .hit_wr_en_i (hit_wr_en),
        .rdata_o     (rdata_o),
        .victim_o    (wr_data_o)
    );

endmodule

`default_nettype wire

/* tb_dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_checker (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         rvalid_i,
    input  wire logic         wvalid_i,
    input  wire logic [31:0]  paddr_i,
    input  wire logic [3:0]   wsel_i,
    input  wire logic [31:0]  wdata_i,
    input  wire logic         stall_o,
    input  wire logic         data_ok_o,
    input  wire logic [31:0]  rdata_o,
    input  wire logic         rd_req_o,
    input  wire logic [31:0]  rd_addr_o,
    input  wire logic         wr_req_o,
    input  wire logic [31:0]  wr_addr_o,
    input  wire logic [255:0] wr_data_o,
    input  wire logic         test_done_i,
    input  wire logic [31:0]  exp_word_i,
    input  wire logic [1:0]   exp_traffic_i,
    output int                err_cnt_o,
    output int                test_cnt_o
);

    // memory as it should look with every write applied at once
    logic [255:0] shadow [logic [26:0]];

    logic        active;
    logic        is_rd;
    logic        test_bad;
    logic        saw_rd;
    logic        saw_wr;
    logic        wr_first;
    logic        saw_stall;
    logic        saw_ok;
    logic [31:0] cur_addr;
    logic [31:0] cur_exp;
    logic [1:0]  cur_traffic;

    initial begin
        err_cnt_o  = 0;
        test_cnt_o = 0;
        active     = 1'b0;
    end

    function automatic logic [255:0] shadow_line(input logic [26:0] la);
        logic [255:0] l;
        if (shadow.exists(la)) begin
            return shadow[la];
        end
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = {la, 5'b0} + 32'(w * 4);
        end
        return l;
    endfunction

    task automatic value_error(input string msg);
        $display("error @%0t ns: %s", $time, msg);
        err_cnt_o++;
        test_bad = 1'b1;
    endtask

    task automatic plain_failure(input string msg);
        $display("test failed because %s", msg);
        err_cnt_o++;
        test_bad = 1'b1;
    endtask

    task automatic apply_write();
        logic [255:0] l;
        logic [31:0]  old_w;
        l     = shadow_line(paddr_i[31:5]);
        old_w = l[paddr_i[4:2]*32 +: 32];
        for (int b = 0; b < 4; b++) begin
            if (wsel_i[b]) begin
                old_w[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
        l[paddr_i[4:2]*32 +: 32] = old_w;
        shadow[paddr_i[31:5]] = l;
    endtask

    task automatic finish_test();
        case (cur_traffic)
            2'd0: if (saw_rd || saw_wr || saw_stall)
                plain_failure("a hit stalled or went to memory");
            2'd1: if (!saw_rd || saw_wr)
                plain_failure("a refill without write-back was expected");
            default: if (!saw_wr || !wr_first || !saw_rd)
                plain_failure("a write-back before the refill was expected");
        endcase
        if (is_rd && !saw_ok) begin
            plain_failure("the read finished without data_ok");
        end
        $display("test %0d addr %h: %s", test_cnt_o + 1, cur_addr, test_bad ? "fail" : "pass");
        test_cnt_o++;
        active = 1'b0;
    endtask

    ////////////////////////////////////////
    // per-cycle monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            if (test_done_i && active) begin
                finish_test();
            end
            if (active) begin
                saw_stall = saw_stall | stall_o;
                if (data_ok_o) begin
                    saw_ok = 1'b1;
                    if (!is_rd) begin
                        plain_failure("data_ok was raised for a write");
                    end else if (rdata_o !== cur_exp) begin
                        value_error($sformatf("rdata %h, expected %h", rdata_o, cur_exp));
                    end
                end
                if (rd_req_o && !saw_rd) begin
                    saw_rd = 1'b1;
                    if (rd_addr_o !== {cur_addr[31:5], 5'b0}) begin
                        value_error($sformatf("rd_addr %h for request %h", rd_addr_o, cur_addr));
                    end
                end
                if (wr_req_o && !saw_wr) begin
                    saw_wr   = 1'b1;
                    wr_first = !saw_rd;
                    if (wr_addr_o[4:0] !== 5'b0 || wr_addr_o[31:5] === cur_addr[31:5]) begin
                        value_error($sformatf("bad write-back address %h", wr_addr_o));
                    end else if (wr_data_o !== shadow_line(wr_addr_o[31:5])) begin
                        value_error($sformatf("write-back line %h differs from memory shadow",
                                              wr_addr_o));
                    end
                end
            end
            // acceptance happens at the coming rising edge
            if ((rvalid_i || wvalid_i) && !stall_o && !active) begin
                active      = 1'b1;
                is_rd       = rvalid_i;
                cur_addr    = paddr_i;
                cur_exp     = exp_word_i;
                cur_traffic = exp_traffic_i;
                test_bad    = 1'b0;
                saw_rd      = 1'b0;
                saw_wr      = 1'b0;
                wr_first    = 1'b0;
                saw_stall   = 1'b0;
                saw_ok      = 1'b0;
                if (wvalid_i) begin
                    apply_write();
                end
            end
        end
    end

    // outputs straight after reset
    initial begin
        @(posedge rst);
        @(negedge clk);
        test_bad = 1'b0;
        if (stall_o || data_ok_o || rd_req_o || wr_req_o) begin
            value_error("outputs not idle after reset");
        end
        $display("reset state: %s", test_bad ? "fail" : "pass");
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int lat_limit = 8;
    localparam int max_tests = 64;

    logic         clk;
    logic         rst;
    logic         rvalid_i;
    logic         wvalid_i;
    logic [31:0]  paddr_i;
    logic [3:0]   wsel_i;
    logic [31:0]  wdata_i;
    logic         stall_o;
    logic         data_ok_o;
    logic [31:0]  rdata_o;
    logic         rd_req_o;
    logic [31:0]  rd_addr_o;
    logic         ret_valid_i;
    logic [255:0] ret_data_i;
    logic         wr_req_o;
    logic [31:0]  wr_addr_o;
    logic [255:0] wr_data_o;
    logic         wr_valid_i;

    logic         test_done;
    logic [31:0]  exp_word;
    logic [1:0]   exp_traffic;
    int           err_cnt;
    int           test_cnt;

    // stimulus table
    logic [7:0]  t_op [max_tests];
    logic [31:0] t_addr [max_tests];
    logic [3:0]  t_strb [max_tests];
    logic [31:0] t_wdata [max_tests];
    int          t_lat [max_tests];
    logic [31:0] t_exp [max_tests];
    int          t_traffic [max_tests];
    int          n_tests;
    int          cur_lat;
    logic        loaded;

    dcache_top uut (.*);

    tb_dcache_checker u_checker (
        .clk (clk), .rst (rst), .rvalid_i (rvalid_i), .wvalid_i (wvalid_i),
        .paddr_i (paddr_i), .wsel_i (wsel_i), .wdata_i (wdata_i),
        .stall_o (stall_o), .data_ok_o (data_ok_o), .rdata_o (rdata_o),
        .rd_req_o (rd_req_o), .rd_addr_o (rd_addr_o), .wr_req_o (wr_req_o),
        .wr_addr_o (wr_addr_o), .wr_data_o (wr_data_o), .test_done_i (test_done),
        .exp_word_i (exp_word), .exp_traffic_i (exp_traffic),
        .err_cnt_o (err_cnt), .test_cnt_o (test_cnt)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // line memory model
    ////////////////////////////////////////

    logic [255:0] mem [logic [26:0]];
    logic         rd_s;
    logic         wr_s;
    logic [31:0]  rd_addr_s;
    logic [31:0]  wr_addr_s;
    logic [255:0] wr_data_s;
    int           wait_cnt;

    function automatic logic [255:0] mem_line(input logic [26:0] la);
        logic [255:0] l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = {la, 5'b0} + 32'(w * 4);
        end
        return l;
    endfunction

    always @(negedge clk) begin
        rd_s      = rd_req_o;
        wr_s      = wr_req_o;
        rd_addr_s = rd_addr_o;
        wr_addr_s = wr_addr_o;
        wr_data_s = wr_data_o;
    end

    always @(posedge clk) begin
        ret_valid_i <= 1'b0;
        wr_valid_i  <= 1'b0;
        if (!rst) begin
            wait_cnt <= 0;
        end else if ((rd_s && !ret_valid_i) || (wr_s && !wr_valid_i)) begin
            if (wait_cnt >= cur_lat) begin
                wait_cnt <= 0;
                if (wr_s) begin
                    mem[wr_addr_s[31:5]] = wr_data_s;
                    wr_valid_i <= 1'b1;
                end else begin
                    ret_data_i  <= mem_line(rd_addr_s[31:5]);
                    ret_valid_i <= 1'b1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        fd = $fopen("dcache_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dcache_stim.txt");
        end else begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %d %h %d", t_op[n_tests],
                                t_addr[n_tests], t_strb[n_tests], t_wdata[n_tests],
                                t_lat[n_tests], t_exp[n_tests], t_traffic[n_tests]);
                    if (n == 7) begin
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        rvalid_i    = 1'b0;
        wvalid_i    = 1'b0;
        paddr_i     = '0;
        wsel_i      = '0;
        wdata_i     = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        wr_valid_i  = 1'b0;
        test_done   = 1'b0;
        exp_word    = '0;
        exp_traffic = '0;
        cur_lat     = 0;
        n_tests     = 0;
        loaded      = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            test_done   <= (i > 0);
            rvalid_i    <= (t_op[i] == "R");
            wvalid_i    <= (t_op[i] == "W");
            paddr_i     <= t_addr[i];
            wsel_i      <= t_strb[i];
            wdata_i     <= t_wdata[i];
            exp_word    <= t_exp[i];
            exp_traffic <= t_traffic[i][1:0];
            cur_lat = (t_lat[i] > lat_limit) ? lat_limit : t_lat[i];
            @(negedge clk);
            while (stall_o) @(negedge clk);
            @(posedge clk);
            rvalid_i  <= 1'b0;
            wvalid_i  <= 1'b0;
            test_done <= 1'b0;
            @(negedge clk);
            while (stall_o) @(negedge clk);
        end
        @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
        @(negedge clk);
        $display("tests %0d of %0d finished, errors %0d", test_cnt, n_tests, err_cnt);
        if (err_cnt == 0 && test_cnt == n_tests && n_tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((n_tests + 1) * (lat_limit + 20) * 8);
        $display("timeout, the cache did not finish the tests in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_stim.txt */
# op addr strobes wdata latency expected_read traffic(0 hit, 1 refill, 2 write-back + refill)
# writes carry an expected read of 00000000, it is not used
R 00001004 0 00000000 0 00001004 1
R 00001008 0 00000000 0 00001008 0
W 00001008 3 aabbccdd 0 00000000 0
R 00001008 0 00000000 0 0000ccdd 0
W 00002010 f 11223344 3 00000000 1
R 00002014 0 00000000 0 00002014 0
R 00003000 0 00000000 2 00003000 2
R 00001008 0 00000000 1 0000ccdd 2
R 00002010 0 00000000 5 11223344 1
R 00001000 0 00000000 0 00001000 0
W 000050a4 4 00ee0000 4 00000000 1
R 000050a4 0 00000000 0 00ee50a4 0
R 000050bc 0 00000000 0 000050bc 0
W 000050a4 8 77000000 0 00000000 0
R 000050a4 0 00000000 0 77ee50a4 0

/* dcache_top.f */
dcache_pkg.sv
dcache_req_stage.sv
dcache_tag_ctrl.sv
dcache_data_store.sv
dcache_top.sv
tb_dcache_checker.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_req_stage.sv
  - dcache_tag_ctrl.sv
  - dcache_data_store.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache_checker.sv
      - tb_dcache.sv
